// ==== hdl/icache_pkg.sv ====
// Instruction cache types
`default_nettype none

package icache_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////
  localparam int vaddr_width       = 32;
  localparam int ptag_width        = 20;
  localparam int page_offset_width = vaddr_width - ptag_width;
  localparam int instr_width       = 32;
  localparam int block_width       = 64;
  localparam int num_ways          = 2;
  localparam int num_sets          = 64;
  localparam int index_width       = 6;
  localparam int way_width         = $clog2(num_ways);
  localparam int tag_entry_width   = 1 + ptag_width;

  //////////////////////////////////////////////////
  // Fetch side
  //////////////////////////////////////////////////
  // Also used for physical addresses, the index sits inside the page offset
  typedef struct packed {
    logic [vaddr_width-index_width-4:0] tag;
    logic [index_width-1:0]             index;
    logic                               word;
    logic [1:0]                         byte_off;
  } icache_vaddr_s;

  typedef enum logic {
    e_op_fetch = 1'b0,
    e_op_fill  = 1'b1
  } icache_op_e;

  typedef struct packed {
    icache_op_e    op;
    icache_vaddr_s vaddr;
  } icache_pkt_s;

  typedef struct packed {
    logic                  valid;
    logic [ptag_width-1:0] ptag;
  } icache_tag_entry_s;

  // Contents of the tag-lookup stage
  typedef struct packed {
    logic          v;
    icache_op_e    op;
    icache_vaddr_s vaddr;
  } tl_entry_s;

  //////////////////////////////////////////////////
  // Cache engine side
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [ptag_width+page_offset_width-1:0] addr;
  } icache_cache_req_s;

  typedef struct packed {
    logic [way_width-1:0] repl_way;
  } icache_req_meta_s;

  typedef enum logic {
    e_fill_tag  = 1'b0,
    e_fill_data = 1'b1
  } fill_op_e;

  typedef struct packed {
    logic [block_width-tag_entry_width-1:0] pad;
    icache_tag_entry_s                      entry;
  } fill_tag_view_s;

  // Same payload word, read as a tag entry or as a whole block
  typedef union packed {
    fill_tag_view_s           tag_view;
    logic [block_width-1:0]   block;
  } fill_payload_u;

  typedef struct packed {
    fill_op_e               op;
    logic [way_width-1:0]   way;
    logic [index_width-1:0] index;
    fill_payload_u          payload;
  } icache_fill_pkt_s;

endpackage

`default_nettype wire

// ==== hdl/icache_fetch_stage.sv ====
// Instruction cache fetch stage
`default_nettype none

module icache_fetch_stage
(
  input  logic                    clk_i,
  input  logic                    reset_i,

  // Decode
  input  icache_pkg::icache_pkt_s icache_pkt_i,
  input  logic                    v_i,
  output logic                    yumi_o,

  // Feedback from tag verify
  input  logic                    tv_ready_i,
  input  logic                    ready_state_i,

  // Tag lookup
  output logic                    tl_advance_o,
  output icache_pkg::tl_entry_s   tl_entry_o
);

  import icache_pkg::*;

  logic        tl_v_r;
  icache_pkt_s tl_pkt_r;

  //////////////////////////////////////////////////
  // Decode acceptance
  //////////////////////////////////////////////////
  // Take a packet when tag lookup is empty or is moving into tag verify
  assign yumi_o       = v_i & ready_state_i & (~tl_v_r | tv_ready_i);
  assign tl_advance_o = yumi_o;

  //////////////////////////////////////////////////
  // Tag lookup registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tl_v_r <= 1'b0;
    end
    else if (yumi_o)
    begin
      tl_v_r <= 1'b1;
    end
    else if (tv_ready_i)
    begin
      // Taken or dropped by tag verify
      tl_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (yumi_o)
    begin
      tl_pkt_r <= icache_pkt_i;
    end
  end

  assign tl_entry_o = '{v: tl_v_r, op: tl_pkt_r.op, vaddr: tl_pkt_r.vaddr};

endmodule

`default_nettype wire

// ==== hdl/icache_arrays.sv ====
// Instruction cache arrays
`default_nettype none

module icache_arrays
(
  input  logic                                clk_i,
  input  logic                                reset_i,

  // Lookup read
  input  logic                                rd_en_i,
  input  logic [icache_pkg::index_width-1:0]  rd_index_i,

  // Fill packets from the cache engine
  input  icache_pkg::icache_fill_pkt_s        fill_pkt_i,
  input  logic                                fill_v_i,
  output logic                                fill_yumi_o,

  // Replacement update from tag verify
  input  logic                                lru_update_v_i,
  input  logic [icache_pkg::index_width-1:0]  lru_update_index_i,
  input  logic [icache_pkg::way_width-1:0]    lru_update_way_i,

  // Read results, held until the next read
  output icache_pkg::icache_tag_entry_s [icache_pkg::num_ways-1:0] tag_entries_o,
  output logic [icache_pkg::num_ways-1:0][icache_pkg::block_width-1:0] data_blocks_o,
  output logic [icache_pkg::way_width-1:0]    lru_way_o
);

  import icache_pkg::*;

  logic [ptag_width-1:0]  ptag_mem [num_ways][num_sets];
  logic [block_width-1:0] data_mem [num_ways][num_sets];
  logic [num_ways-1:0][num_sets-1:0]  valid_r;
  logic [num_sets-1:0][way_width-1:0] lru_r;
  logic [index_width-1:0] rd_index_r;
  logic                   tag_we;
  logic                   data_we;

  //////////////////////////////////////////////////
  // Fill decode and arbitration
  //////////////////////////////////////////////////
  // Lookup reads win, a fill waits for an idle cycle
  assign fill_yumi_o = fill_v_i & ~rd_en_i;
  assign tag_we      = fill_yumi_o & (fill_pkt_i.op == e_fill_tag);
  assign data_we     = fill_yumi_o & (fill_pkt_i.op == e_fill_data);

  //////////////////////////////////////////////////
  // Tag and data memories
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (tag_we)
    begin
      ptag_mem[fill_pkt_i.way][fill_pkt_i.index] <= fill_pkt_i.payload.tag_view.entry.ptag;
    end
    if (data_we)
    begin
      data_mem[fill_pkt_i.way][fill_pkt_i.index] <= fill_pkt_i.payload.block;
    end
    if (rd_en_i)
    begin
      rd_index_r <= rd_index_i;
      for (int w = 0; w < num_ways; w++)
      begin
        tag_entries_o[w].valid <= valid_r[w][rd_index_i];
        tag_entries_o[w].ptag  <= ptag_mem[w][rd_index_i];
        data_blocks_o[w]       <= data_mem[w][rd_index_i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Valid and LRU bits
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r <= '0;
      lru_r   <= '0;
    end
    else
    begin
      if (tag_we)
      begin
        valid_r[fill_pkt_i.way][fill_pkt_i.index] <= fill_pkt_i.payload.tag_view.entry.valid;
      end
      // The bit names the way to replace next
      if (lru_update_v_i)
      begin
        lru_r[lru_update_index_i] <= ~lru_update_way_i;
      end
    end
  end

  // Forward an update to the same set so tag verify never sees a stale bit
  assign lru_way_o = (lru_update_v_i && (lru_update_index_i == rd_index_r))
                   ? ~lru_update_way_i
                   : lru_r[rd_index_r];

endmodule

`default_nettype wire

// ==== hdl/icache_verify_stage.sv ====
// Instruction cache verify stage
`default_nettype none

module icache_verify_stage
(
  input  logic                                clk_i,
  input  logic                                reset_i,

  // Tag lookup entry and translation
  input  icache_pkg::tl_entry_s               tl_entry_i,
  input  logic [icache_pkg::ptag_width-1:0]   ptag_i,
  input  logic                                ptag_v_i,
  input  icache_pkg::icache_tag_entry_s [icache_pkg::num_ways-1:0] tag_entries_i,
  input  logic [icache_pkg::num_ways-1:0][icache_pkg::block_width-1:0] data_blocks_i,
  input  logic [icache_pkg::way_width-1:0]    lru_way_i,

  // Pipeline control
  output logic                                tv_ready_o,
  output logic                                ready_state_o,
  output logic                                recovering_o,

  // Result
  output logic [icache_pkg::instr_width-1:0]  data_o,
  output logic                                miss_not_data_o,
  output logic                                data_v_o,
  input  logic                                data_yumi_i,

  // Cache engine
  output icache_pkg::icache_cache_req_s       cache_req_o,
  output logic                                cache_req_v_o,
  input  logic                                cache_req_ready_i,
  output icache_pkg::icache_req_meta_s        cache_req_metadata_o,
  output logic                                cache_req_metadata_v_o,
  input  logic                                cache_req_complete_i,

  // Replacement update
  output logic                                lru_update_v_o,
  output logic [icache_pkg::index_width-1:0]  lru_update_index_o,
  output logic [icache_pkg::way_width-1:0]    lru_update_way_o
);

  import icache_pkg::*;

  typedef enum logic [1:0] {e_ready, e_miss, e_recover} state_e;

  state_e                 state_r, state_n;
  logic                   tv_v_r, take, pending;
  logic [num_ways-1:0]    hit_n, hit_r, way_v_r;
  logic [block_width-1:0] block_n, block_r;
  icache_vaddr_s          paddr_n, paddr_r;
  icache_op_e             op_r;
  logic                   complete_r;
  logic [way_width-1:0]   lru_r, hit_way, invalid_way;
  logic                   invalid_exist;

  //////////////////////////////////////////////////
  // Tag compare against the incoming ptag
  //////////////////////////////////////////////////
  assign tv_ready_o = ~tv_v_r | (data_v_o & data_yumi_i);
  assign take       = tv_ready_o & tl_entry_i.v & ptag_v_i;
  assign paddr_n    = icache_vaddr_s'({ptag_i, tl_entry_i.vaddr[page_offset_width-1:0]});

  always_comb
  begin
    block_n = '0;
    for (int w = 0; w < num_ways; w++)
    begin
      hit_n[w] = tag_entries_i[w].valid & (tag_entries_i[w].ptag == ptag_i);
      block_n  = block_n | ({block_width{hit_n[w]}} & data_blocks_i[w]);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tv_v_r <= 1'b0;
    else if (take)
      tv_v_r <= 1'b1;
    else if (tv_ready_o)
      tv_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      hit_r      <= hit_n;
      block_r    <= block_n;
      paddr_r    <= paddr_n;
      op_r       <= tl_entry_i.op;
      complete_r <= (tl_entry_i.op == e_op_fetch) | (|hit_n);
      lru_r      <= lru_way_i;
      for (int w = 0; w < num_ways; w++)
        way_v_r[w] <= tag_entries_i[w].valid;
    end
    else if (state_r == e_recover)
      complete_r <= 1'b1;
  end

  //////////////////////////////////////////////////
  // Result and replacement
  //////////////////////////////////////////////////
  assign data_v_o        = tv_v_r & complete_r;
  assign miss_not_data_o = data_v_o & (~(|hit_r) | (op_r == e_op_fill));
  assign data_o          = block_r[paddr_r.word*instr_width +: instr_width];

  // Lowest invalid way wins, scanned from the top down
  always_comb
  begin
    invalid_exist = 1'b0;
    invalid_way   = '0;
    hit_way       = '0;
    for (int w = num_ways-1; w >= 0; w--)
    begin
      if (!way_v_r[w])
      begin
        invalid_exist = 1'b1;
        invalid_way   = way_width'(w);
      end
      if (hit_r[w])
        hit_way = way_width'(w);
    end
  end

  assign lru_update_v_o     = tv_v_r & (op_r == e_op_fetch) & (|hit_r);
  assign lru_update_index_o = paddr_r.index;
  assign lru_update_way_o   = hit_way;

  //////////////////////////////////////////////////
  // Miss request and state machine
  //////////////////////////////////////////////////
  assign pending       = tv_v_r & ~complete_r;
  // Decode is held off while a fill miss waits or is serviced
  assign ready_state_o = (state_r == e_ready) & ~pending;
  assign recovering_o  = (state_r == e_recover);
  assign cache_req_v_o = (state_r == e_ready) & pending & cache_req_ready_i;
  assign cache_req_o   = '{addr: {paddr_r.tag, paddr_r.index, 3'b000}};
  assign cache_req_metadata_o = '{repl_way: invalid_exist ? invalid_way : lru_r};

  always_comb
  begin
    case (state_r)
      e_ready:   state_n = cache_req_v_o ? e_miss : e_ready;
      e_miss:    state_n = cache_req_complete_i ? e_recover : e_miss;
      e_recover: state_n = e_ready;
      default:   state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r                <= e_ready;
      cache_req_metadata_v_o <= 1'b0;
    end
    else
    begin
      state_r                <= state_n;
      cache_req_metadata_v_o <= cache_req_v_o;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
// Instruction cache top level
`default_nettype none

module icache_top
(
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  icache_pkg::icache_pkt_s             icache_pkt_i,
  input  logic                                v_i,
  output logic                                yumi_o,

  input  logic [icache_pkg::ptag_width-1:0]   ptag_i,
  input  logic                                ptag_v_i,

  output logic [icache_pkg::instr_width-1:0]  data_o,
  output logic                                miss_not_data_o,
  output logic                                data_v_o,
  input  logic                                data_yumi_i,

  output icache_pkg::icache_cache_req_s       cache_req_o,
  output logic                                cache_req_v_o,
  input  logic                                cache_req_ready_i,
  output icache_pkg::icache_req_meta_s        cache_req_metadata_o,
  output logic                                cache_req_metadata_v_o,
  input  icache_pkg::icache_fill_pkt_s        fill_pkt_i,
  input  logic                                fill_v_i,
  output logic                                fill_yumi_o,
  input  logic                                cache_req_complete_i
);

  import icache_pkg::*;

  tl_entry_s                            tl_entry;
  logic                                 tl_advance, tv_ready, recovering, ready_state;
  logic                                 rd_en;
  logic [index_width-1:0]               rd_index;
  logic                                 lru_update_v;
  logic [index_width-1:0]               lru_update_index;
  logic [way_width-1:0]                 lru_update_way, lru_way;
  icache_tag_entry_s [num_ways-1:0]     tag_entries;
  logic [num_ways-1:0][block_width-1:0] data_blocks;

  // Recover re-reads the set of the entry held in tag lookup
  assign rd_en    = tl_advance | recovering;
  assign rd_index = tl_advance ? icache_pkt_i.vaddr.index : tl_entry.vaddr.index;

  icache_fetch_stage fetch
  (
    .clk_i, .reset_i, .icache_pkt_i, .v_i, .yumi_o,
    .tv_ready_i(tv_ready), .ready_state_i(ready_state),
    .tl_advance_o(tl_advance), .tl_entry_o(tl_entry)
  );

  icache_arrays arrays
  (
    .clk_i, .reset_i, .rd_en_i(rd_en), .rd_index_i(rd_index),
    .fill_pkt_i, .fill_v_i, .fill_yumi_o,
    .lru_update_v_i(lru_update_v), .lru_update_index_i(lru_update_index),
    .lru_update_way_i(lru_update_way),
    .tag_entries_o(tag_entries), .data_blocks_o(data_blocks), .lru_way_o(lru_way)
  );

  icache_verify_stage verify
  (
    .clk_i, .reset_i, .tl_entry_i(tl_entry), .ptag_i, .ptag_v_i,
    .tag_entries_i(tag_entries), .data_blocks_i(data_blocks), .lru_way_i(lru_way),
    .tv_ready_o(tv_ready), .ready_state_o(ready_state), .recovering_o(recovering),
    .data_o, .miss_not_data_o, .data_v_o, .data_yumi_i,
    .cache_req_o, .cache_req_v_o, .cache_req_ready_i,
    .cache_req_metadata_o, .cache_req_metadata_v_o, .cache_req_complete_i,
    .lru_update_v_o(lru_update_v), .lru_update_index_o(lru_update_index),
    .lru_update_way_o(lru_update_way)
  );

endmodule

`default_nettype wire

// ==== test/icache_asserts.sv ====
// Instruction cache port assertions
`default_nettype none

module icache_asserts
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                yumi_o,
  input  logic [icache_pkg::instr_width-1:0]  data_o,
  input  logic                                miss_not_data_o,
  input  logic                                data_v_o,
  input  logic                                data_yumi_i,
  input  icache_pkg::icache_cache_req_s       cache_req_o,
  input  logic                                cache_req_v_o,
  input  logic                                cache_req_ready_i,
  input  logic                                cache_req_metadata_v_o,
  input  logic                                cache_req_complete_i,
  input  logic                                fill_v_i,
  input  logic                                fill_yumi_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int   fail_count = 0;
  logic miss_r;
  logic recover_r;

  // Tracks the span from request to the recover cycle
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      miss_r    <= 1'b0;
      recover_r <= 1'b0;
    end
    else
    begin
      if (cache_req_v_o)
        miss_r <= 1'b1;
      else if (cache_req_complete_i)
        miss_r <= 1'b0;
      recover_r <= miss_r & cache_req_complete_i;
    end
  end

  //////////////////////////////////////////////////
  // Reset and engine handshake
  //////////////////////////////////////////////////
  reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> !data_v_o && !cache_req_v_o && !cache_req_metadata_v_o)
    else begin $error("Outputs active after reset"); fail_count++; end

  fill_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !fill_v_i |-> !fill_yumi_o)
    else begin $error("fill_yumi_o without fill_v_i"); fail_count++; end

  req_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_o |-> cache_req_ready_i)
    else begin $error("Request while engine not ready"); fail_count++; end

  req_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_o |=> !cache_req_v_o)
    else begin $error("Request longer than one cycle"); fail_count++; end

  req_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_o |-> (cache_req_o.addr[2:0] == 3'b000))
    else begin $error("Request address not block aligned"); fail_count++; end

  meta_follows: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_metadata_v_o == $past(cache_req_v_o))
    else begin $error("Metadata valid not one cycle after request"); fail_count++; end

  //////////////////////////////////////////////////
  // Result and decode
  //////////////////////////////////////////////////
  result_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o && !data_yumi_i |=> data_v_o && $stable(data_o) && $stable(miss_not_data_o))
    else begin $error("Result changed before data_yumi_i"); fail_count++; end

  no_accept_in_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    (cache_req_v_o || miss_r || recover_r) |-> !yumi_o)
    else begin $error("Packet accepted during miss service"); fail_count++; end

  fill_done: assert property (@(posedge clk_i) disable iff (reset_i)
    recover_r |=> data_v_o && miss_not_data_o)
    else begin $error("No miss result after recover"); fail_count++; end

endmodule

bind icache_top icache_asserts asserts (.*);

`default_nettype wire

// ==== test/icache_tb.sv ====
// Instruction cache testbench
`default_nettype none

module icache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import icache_pkg::*;

  localparam int num_random  = 40;
  localparam int max_ops     = 3 + 2 * num_random;
  localparam int cycle_limit = 40 * max_ops + 100;
  localparam logic [ptag_width-1:0] ptag_offset = 20'h00400;

  logic                   clk_i = 1'b0;
  logic                   reset_i;
  icache_pkt_s            icache_pkt_i;
  logic                   v_i, yumi_o;
  logic [ptag_width-1:0]  ptag_i;
  logic                   ptag_v_i;
  logic [instr_width-1:0] data_o;
  logic                   miss_not_data_o, data_v_o, data_yumi_i;
  icache_cache_req_s      cache_req_o;
  logic                   cache_req_v_o, cache_req_ready_i;
  icache_req_meta_s       cache_req_metadata_o;
  logic                   cache_req_metadata_v_o;
  icache_fill_pkt_s       fill_pkt_i;
  logic                   fill_v_i, fill_yumi_o, cache_req_complete_i;

  int seed         = 4;
  int main_errors  = 0;
  int engine_errors = 0;
  int ops_done     = 0;
  int cycle_count  = 0;

  // Shadow tag model where the LRU bit names the way to replace next
  logic                  sh_valid [num_ways][num_sets];
  logic [ptag_width-1:0] sh_tag   [num_ways][num_sets];
  logic [way_width-1:0]  sh_lru   [num_sets];

  logic [vaddr_width-1:0] exp_req_addr;
  logic [way_width-1:0]   exp_way;
  icache_op_e             rnd_op [num_random];
  icache_vaddr_s          rnd_va [num_random];

  // Three pages and three sets so that lines get evicted
  logic [19:0]            vpns [3] = '{20'h00010, 20'h00023, 20'h00035};
  logic [index_width-1:0] sets [3] = '{6'd5, 6'd17, 6'd42};

  icache_top dut (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Memory model and checking helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ 32'h5a5a_c3c3;
  endfunction

  function automatic int report_mismatch(input string name, input logic [31:0] seen,
                                         input logic [31:0] expected);
    if (seen !== expected)
    begin
      $display("[ERROR] %0t %s seen %0h expected %0h", $time, name, seen, expected);
      return 1;
    end
    return 0;
  endfunction

  task automatic send_fill(input fill_op_e fop, input logic [way_width-1:0] way,
                           input logic [31:0] addr, input logic [block_width-1:0] payload);
    @(negedge clk_i);
    fill_pkt_i.op            = fop;
    fill_pkt_i.way           = way;
    fill_pkt_i.index         = addr[8:3];
    fill_pkt_i.payload.block = payload;
    fill_v_i                 = 1'b1;
    #1;
    while (!fill_yumi_o)
    begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    fill_v_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // One operation through the pipeline
  //////////////////////////////////////////////////
  task automatic run_op(input icache_op_e op, input icache_vaddr_s va);
    logic [ptag_width-1:0]  pt;
    logic [index_width-1:0] idx;
    logic                   hit;
    logic [way_width-1:0]   hit_way;
    pt      = va[31:12] + ptag_offset;
    idx     = va.index;
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < num_ways; w++)
    begin
      if (sh_valid[w][idx] && (sh_tag[w][idx] == pt))
      begin
        hit     = 1'b1;
        hit_way = way_width'(w);
      end
    end
    // Lowest invalid way first, then the LRU way
    exp_req_addr = {pt, va[11:3], 3'b000};
    exp_way      = sh_lru[idx];
    for (int w = num_ways - 1; w >= 0; w--)
    begin
      if (!sh_valid[w][idx])
        exp_way = way_width'(w);
    end

    @(negedge clk_i);
    icache_pkt_i.op    = op;
    icache_pkt_i.vaddr = va;
    v_i                = 1'b1;
    #1;
    while (!yumi_o)
    begin
      @(negedge clk_i);
      #1;
    end
    // Tag lookup cycle
    @(negedge clk_i);
    v_i      = 1'b0;
    ptag_i   = pt;
    ptag_v_i = 1'b1;
    @(negedge clk_i);
    ptag_v_i = 1'b0;
    #1;
    if ((op == e_op_fill) && !hit)
    begin
      // Decode must hold off a packet offered during miss service
      v_i = 1'b1;
      while (!data_v_o)
      begin
        @(negedge clk_i);
        #1;
      end
      v_i                    = 1'b0;
      sh_valid[exp_way][idx] = 1'b1;
      sh_tag[exp_way][idx]   = pt;
    end
    else
      main_errors += report_mismatch("data_v_o", 32'(data_v_o), 32'd1);
    main_errors += report_mismatch("miss_not_data_o", 32'(miss_not_data_o),
                                   32'((op == e_op_fill) || !hit));
    if ((op == e_op_fetch) && hit)
    begin
      main_errors += report_mismatch("data_o", data_o, mem_word({pt, va[11:2], 2'b00}));
      sh_lru[idx] = ~hit_way;
    end
    repeat (ops_done % 3) @(negedge clk_i);
    data_yumi_i = 1'b1;
    @(negedge clk_i);
    data_yumi_i = 1'b0;
    ops_done++;
  endtask

  //////////////////////////////////////////////////
  // Cache engine model
  //////////////////////////////////////////////////
  initial
  begin : engine
    logic [vaddr_width-1:0] req_addr;
    logic [way_width-1:0]   way;
    int                     low_left;
    low_left             = 0;
    cache_req_ready_i    = 1'b0;
    cache_req_complete_i = 1'b0;
    fill_pkt_i           = '0;
    fill_v_i             = 1'b0;
    forever
    begin
      @(negedge clk_i);
      if (low_left > 0)
      begin
        low_left--;
        cache_req_ready_i = 1'b0;
      end
      else if (($unsigned($random(seed)) % 4) == 0)
      begin
        low_left          = 1 + ($unsigned($random(seed)) % 4);
        cache_req_ready_i = 1'b0;
      end
      else
        cache_req_ready_i = 1'b1;
      #1;
      if (!reset_i && cache_req_v_o)
      begin
        req_addr = cache_req_o.addr;
        engine_errors += report_mismatch("cache_req_o", req_addr, exp_req_addr);
        @(negedge clk_i);
        cache_req_ready_i = 1'b0;
        #1;
        way = cache_req_metadata_o.repl_way;
        engine_errors += report_mismatch("cache_req_metadata_o", 32'(way), 32'(exp_way));
        send_fill(e_fill_tag, way, req_addr, {43'b0, 1'b1, req_addr[31:12]});
        send_fill(e_fill_data, way, req_addr,
                  {mem_word(req_addr + 32'd4), mem_word(req_addr)});
        @(negedge clk_i);
        cache_req_complete_i = 1'b1;
        @(negedge clk_i);
        cache_req_complete_i = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial
  begin : stimulus
    int   assert_errors;
    int   t_sel;
    int   s_sel;
    logic w_sel;
    reset_i      = 1'b1;
    icache_pkt_i = '0;
    v_i          = 1'b0;
    ptag_i       = '0;
    ptag_v_i     = 1'b0;
    data_yumi_i  = 1'b0;
    for (int s = 0; s < num_sets; s++)
    begin
      sh_lru[s] = '0;
      for (int w = 0; w < num_ways; w++)
        sh_valid[w][s] = 1'b0;
    end
    for (int i = 0; i < num_random; i++)
    begin
      rnd_op[i] = (($unsigned($random(seed)) % 2) == 0) ? e_op_fill : e_op_fetch;
      t_sel     = int'($unsigned($random(seed)) % 3);
      s_sel     = int'($unsigned($random(seed)) % 3);
      w_sel     = (($unsigned($random(seed)) % 2) == 1);
      rnd_va[i] = {vpns[t_sel], 3'b000, sets[s_sel], w_sel, 2'b00};
    end

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // First fetch to each cold set misses
    for (int s = 0; s < 3; s++)
      run_op(e_op_fetch, {vpns[s], 3'b000, sets[s], 1'b0, 2'b00});

    for (int i = 0; i < num_random; i++)
    begin
      run_op(rnd_op[i], rnd_va[i]);
      if (rnd_op[i] == e_op_fill)
        run_op(e_op_fetch, rnd_va[i]);
    end

    repeat (4) @(negedge clk_i);
    assert_errors = dut.asserts.fail_count;
    $display("Errors: %0d result, %0d engine, %0d assertion",
             main_errors, engine_errors, assert_errors);
    if ((main_errors + engine_errors + assert_errors) == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/icache_pkg.sv
hdl/icache_fetch_stage.sv
hdl/icache_arrays.sv
hdl/icache_verify_stage.sv
hdl/icache_top.sv
test/icache_asserts.sv
test/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --timing --timescale 1ns/1ps --top-module icache_tb \
  -f flist.f -o icache_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/icache_sim +verilator+error+limit+1000 > sim.log 2>&1 || { cat sim.log; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
